// ==== sd_settings.svh ====
/* SD controller build constants: sclk dividers, response and busy timeouts, block size */
`ifndef SD_SETTINGS_SVH
`define SD_SETTINGS_SVH

// clk cycles per sclk half-period, both must be 2 or more
// power-up rate must stay under 400 kHz, kept small for simulation
`define SD_INIT_DIV 8
`define SD_FAST_DIV 2

`define SD_BLOCK_BYTES 512

// limits counted in byte exchanges
`define SD_RESP_TIMEOUT 64
`define SD_BUSY_TIMEOUT 256
`define SD_ACMD41_TRIES 16

`endif

// ==== sd_pkg.sv ====
/* SD controller types: command frame, response kinds and sequencer states */
package sd_pkg;

    // one command frame before start bits and end bit are added
    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        logic [6:0]  crc;
    } sd_cmd_t;

    // R3 and R7 carry four bytes after the R1 byte
    typedef enum logic [1:0] {RESP_R1, RESP_R3, RESP_R7} sd_resp_kind_t;

    typedef enum logic [3:0] {
        ST_POWER_IDLE, ST_CMD_SEND, ST_RESP_WAIT, ST_RESP_EXTRA, ST_CHECK,
        ST_READY, ST_TOKEN_WAIT, ST_READ_DATA, ST_READ_CRC, ST_WRITE_TOKEN,
        ST_WRITE_DATA, ST_WRITE_CRC, ST_DRESP, ST_BUSY_WAIT, ST_FAIL
    } sd_seq_state_t;

    localparam logic [5:0] CMD0  = 6'd0;
    localparam logic [5:0] CMD8  = 6'd8;
    localparam logic [5:0] CMD16 = 6'd16;
    localparam logic [5:0] CMD17 = 6'd17;
    localparam logic [5:0] CMD24 = 6'd24;
    localparam logic [5:0] CMD41 = 6'd41;
    localparam logic [5:0] CMD55 = 6'd55;
    localparam logic [5:0] CMD58 = 6'd58;

endpackage

// ==== spi_byte_if.sv ====
/* byte request channel between the command sequencer and the SPI shifter */
`timescale 1ns/1ps

interface spi_byte_if;
    logic       start;
    logic [7:0] tx_byte;
    logic       fast;
    logic       busy;
    logic       done;
    logic [7:0] rx_byte;

    modport seq (
        output start, tx_byte, fast,
        input  busy, done, rx_byte
    );

    modport phy (
        input  start, tx_byte, fast,
        output busy, done, rx_byte
    );
endinterface

// ==== sd_spi_shifter.sv ====
/* SPI mode 0 byte engine: one byte out on mosi and one in from miso per request */
`timescale 1ns/1ps
`include "sd_settings.svh"

module sd_spi_shifter (
    input  logic    clk,
    input  logic    reset,
    spi_byte_if.phy bus,
    output logic    mosi,
    input  logic    miso,
    output logic    sclk
);
    logic [7:0] div_cnt;
    logic [7:0] div_reload;
    logic [3:0] half_cnt;
    logic [7:0] tx_sh;
    logic [7:0] rx_sh;
    logic       fast_q;
    logic       edge_now;

    assign div_reload  = fast_q ? 8'(`SD_FAST_DIV - 1) : 8'(`SD_INIT_DIV - 1);
    assign edge_now    = bus.busy && (div_cnt == 8'd0);
    assign mosi        = bus.busy ? tx_sh[7] : 1'b1;
    assign bus.rx_byte = rx_sh;

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.busy <= 1'b0;
            bus.done <= 1'b0;
            sclk     <= 1'b0;
            fast_q   <= 1'b0;
            div_cnt  <= '0;
            half_cnt <= '0;
        end else begin
            bus.done <= 1'b0;
            if (!bus.busy) begin
                if (bus.start) begin
                    bus.busy <= 1'b1;
                    fast_q   <= bus.fast;
                    half_cnt <= '0;
                    // load cycle counts toward the first half-period
                    div_cnt  <= bus.fast ? 8'(`SD_FAST_DIV - 2) : 8'(`SD_INIT_DIV - 2);
                end
            end else if (edge_now) begin
                sclk     <= ~sclk;
                div_cnt  <= div_reload;
                half_cnt <= half_cnt + 4'd1;
                // eighth falling edge ends the byte
                if (half_cnt == 4'd15) begin
                    bus.busy <= 1'b0;
                    bus.done <= 1'b1;
                end
            end else begin
                div_cnt <= div_cnt - 8'd1;
            end
        end
    end

    // sample on rising sclk, shift on falling sclk
    always_ff @(posedge clk) begin
        if (!bus.busy && bus.start) begin
            tx_sh <= bus.tx_byte;
        end else if (edge_now) begin
            if (!sclk) begin
                rx_sh <= {rx_sh[6:0], miso};
            end else begin
                tx_sh <= {tx_sh[6:0], 1'b1};
            end
        end
    end

endmodule

// ==== sd_cmd_sequencer.sv ====
/* SD command sequencer: power-up, CMD17/CMD24 block transfers and response
   checks, one byte exchange at a time through the shifter */
`timescale 1ns/1ps
`include "sd_settings.svh"

module sd_cmd_sequencer import sd_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    spi_byte_if.seq     bus,
    output logic        cs,
    input  logic        rd,
    input  logic        wr,
    input  logic [31:0] address,
    input  logic [7:0]  din,
    output logic [7:0]  dout,
    output logic        byte_available,
    output logic        ready_for_next_byte,
    output logic        ready,
    output logic        error
);
    localparam logic [9:0]  LAST_BYTE = 10'(`SD_BLOCK_BYTES - 1);
    localparam logic [15:0] RESP_LAST = 16'(`SD_RESP_TIMEOUT - 1);
    localparam logic [15:0] BUSY_LAST = 16'(`SD_BUSY_TIMEOUT - 1);
    localparam logic [7:0]  TRY_LAST  = 8'(`SD_ACMD41_TRIES - 1);
    localparam logic [9:0]  IDLE_LAST = 10'd9;  // 80 clocks with cs high

    sd_seq_state_t state;
    sd_cmd_t       cmd;
    sd_resp_kind_t kind;
    logic [5:0]    chk_idx;
    logic          chk_ok;
    logic [9:0]    cnt;
    logic [15:0]   tmo;
    logic [7:0]    tries;
    logic [7:0]    r1;
    logic [7:0]    extra;
    logic [7:0]    tx_next;
    logic          pending;
    logic          init_done;
    logic          want_next;

    function automatic sd_cmd_t make_cmd(input logic [5:0] idx, input logic [31:0] addr);
        sd_cmd_t c;
        c.index = idx;
        c.arg   = 32'd0;
        c.crc   = 7'h7F;
        case (idx)
            CMD0:  c.crc = 7'h4A;
            CMD8: begin
                c.arg = 32'h0000_01AA;
                c.crc = 7'h43;
            end
            CMD41: c.arg = 32'h4000_0000;  // HCS set
            CMD16: c.arg = 32'(`SD_BLOCK_BYTES);
            CMD17, CMD24: c.arg = addr;
            default: c.arg = 32'd0;
        endcase
        return c;
    endfunction

    function automatic sd_resp_kind_t kind_of(input logic [5:0] idx);
        if (idx == CMD8) return RESP_R7;
        if (idx == CMD58) return RESP_R3;
        return RESP_R1;
    endfunction

    assign ready     = (state == ST_READY);
    assign bus.fast  = init_done;
    // one request per data byte, issued with the exchange before it
    assign want_next = (state == ST_WRITE_TOKEN) ||
                       (state == ST_WRITE_DATA && cnt != LAST_BYTE);

    always_comb begin
        case (state)
            ST_CMD_SEND: begin
                case (cnt[2:0])
                    3'd1:    tx_next = {2'b01, cmd.index};
                    3'd2:    tx_next = cmd.arg[31:24];
                    3'd3:    tx_next = cmd.arg[23:16];
                    3'd4:    tx_next = cmd.arg[15:8];
                    3'd5:    tx_next = cmd.arg[7:0];
                    3'd6:    tx_next = {cmd.crc, 1'b1};
                    default: tx_next = 8'hFF;
                endcase
            end
            ST_WRITE_TOKEN: tx_next = 8'hFE;
            ST_WRITE_DATA:  tx_next = din;
            default:        tx_next = 8'hFF;
        endcase
    end

    // response check and next power-up command
    always_comb begin
        case (cmd.index)
            CMD0: begin
                chk_ok  = (r1 == 8'h01);
                chk_idx = CMD8;
            end
            CMD8: begin
                chk_ok  = (r1 == 8'h01) && (extra == 8'hAA);
                chk_idx = CMD55;
            end
            CMD55: begin
                chk_ok  = (r1[6:1] == 6'd0);
                chk_idx = CMD41;
            end
            CMD41: begin
                chk_ok  = (r1 == 8'h00) || (r1 == 8'h01 && tries != TRY_LAST);
                chk_idx = (r1 == 8'h00) ? CMD58 : CMD55;
            end
            default: begin
                chk_ok  = (r1 == 8'h00);
                chk_idx = CMD16;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state               <= ST_POWER_IDLE;
            cs                  <= 1'b1;
            pending             <= 1'b0;
            bus.start           <= 1'b0;
            byte_available      <= 1'b0;
            ready_for_next_byte <= 1'b0;
            error               <= 1'b0;
            init_done           <= 1'b0;
            cnt                 <= '0;
            tmo                 <= '0;
            tries               <= '0;
        end else begin
            bus.start           <= 1'b0;
            byte_available      <= 1'b0;
            ready_for_next_byte <= 1'b0;
            error               <= 1'b0;
            cs <= (state == ST_POWER_IDLE) || (state == ST_READY) || (state == ST_FAIL);
            case (state)
                ST_READY: begin
                    if (rd || wr) begin
                        cmd   <= make_cmd(rd ? CMD17 : CMD24, address);
                        kind  <= RESP_R1;
                        cnt   <= '0;
                        state <= ST_CMD_SEND;
                    end
                end
                ST_CHECK: begin
                    cnt  <= '0;
                    tmo  <= '0;
                    cmd  <= make_cmd(chk_idx, 32'd0);
                    kind <= kind_of(chk_idx);
                    if (cmd.index == CMD41 && r1 == 8'h01) begin
                        tries <= tries + 8'd1;
                    end
                    if (!chk_ok) begin
                        state <= ST_FAIL;
                    end else if (cmd.index == CMD16) begin
                        init_done <= 1'b1;
                        state     <= ST_READY;
                    end else if (cmd.index == CMD17) begin
                        state <= ST_TOKEN_WAIT;
                    end else if (cmd.index == CMD24) begin
                        state <= ST_WRITE_TOKEN;
                    end else begin
                        state <= ST_CMD_SEND;
                    end
                end
                ST_FAIL: begin
                    // power-up failures start over from the idle clocks
                    error <= 1'b1;
                    cnt   <= '0;
                    state <= init_done ? ST_READY : ST_POWER_IDLE;
                end
                default: begin
                    if (!pending && !bus.busy) begin
                        bus.start           <= 1'b1;
                        bus.tx_byte         <= tx_next;
                        ready_for_next_byte <= want_next;
                        pending             <= 1'b1;
                    end else if (bus.done) begin
                        pending <= 1'b0;
                        case (state)
                            ST_POWER_IDLE: begin
                                if (cnt == IDLE_LAST) begin
                                    cmd   <= make_cmd(CMD0, 32'd0);
                                    kind  <= RESP_R1;
                                    tries <= '0;
                                    cnt   <= '0;
                                    state <= ST_CMD_SEND;
                                end else begin
                                    cnt <= cnt + 10'd1;
                                end
                            end
                            ST_CMD_SEND: begin
                                if (cnt == 10'd6) begin
                                    tmo   <= '0;
                                    state <= ST_RESP_WAIT;
                                end else begin
                                    cnt <= cnt + 10'd1;
                                end
                            end
                            ST_RESP_WAIT: begin
                                if (!bus.rx_byte[7]) begin
                                    r1    <= bus.rx_byte;
                                    cnt   <= '0;
                                    state <= (kind == RESP_R1) ? ST_CHECK : ST_RESP_EXTRA;
                                end else if (tmo == RESP_LAST) begin
                                    state <= ST_FAIL;
                                end else begin
                                    tmo <= tmo + 16'd1;
                                end
                            end
                            ST_RESP_EXTRA: begin
                                // last byte holds the CMD8 check pattern
                                extra <= bus.rx_byte;
                                if (cnt == 10'd3) begin
                                    state <= ST_CHECK;
                                end else begin
                                    cnt <= cnt + 10'd1;
                                end
                            end
                            ST_TOKEN_WAIT: begin
                                if (bus.rx_byte == 8'hFE) begin
                                    cnt   <= '0;
                                    state <= ST_READ_DATA;
                                end else if (bus.rx_byte != 8'hFF || tmo == RESP_LAST) begin
                                    state <= ST_FAIL;  // error token or no token
                                end else begin
                                    tmo <= tmo + 16'd1;
                                end
                            end
                            ST_READ_DATA: begin
                                dout           <= bus.rx_byte;
                                byte_available <= 1'b1;
                                if (cnt == LAST_BYTE) begin
                                    cnt   <= '0;
                                    state <= ST_READ_CRC;
                                end else begin
                                    cnt <= cnt + 10'd1;
                                end
                            end
                            ST_WRITE_TOKEN: begin
                                cnt   <= '0;
                                state <= ST_WRITE_DATA;
                            end
                            ST_WRITE_DATA: begin
                                if (cnt == LAST_BYTE) begin
                                    cnt   <= '0;
                                    state <= ST_WRITE_CRC;
                                end else begin
                                    cnt <= cnt + 10'd1;
                                end
                            end
                            ST_READ_CRC, ST_WRITE_CRC: begin
                                // two crc bytes, ignored on read and dummy on write
                                if (cnt == 10'd1) begin
                                    tmo   <= '0;
                                    state <= (state == ST_READ_CRC) ? ST_READY : ST_DRESP;
                                end else begin
                                    cnt <= cnt + 10'd1;
                                end
                            end
                            ST_DRESP: begin
                                if (bus.rx_byte != 8'hFF) begin
                                    tmo   <= '0;
                                    state <= (bus.rx_byte[4:0] == 5'b00101) ? ST_BUSY_WAIT
                                                                             : ST_FAIL;
                                end else if (tmo == RESP_LAST) begin
                                    state <= ST_FAIL;
                                end else begin
                                    tmo <= tmo + 16'd1;
                                end
                            end
                            ST_BUSY_WAIT: begin
                                // card holds miso low while programming
                                if (bus.rx_byte == 8'hFF) begin
                                    state <= ST_READY;
                                end else if (tmo == BUSY_LAST) begin
                                    state <= ST_FAIL;
                                end else begin
                                    tmo <= tmo + 16'd1;
                                end
                            end
                            default: state <= ST_FAIL;
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

// ==== sd_controller_top.sv ====
/* SPI-mode SD card controller top: command sequencer and SPI byte shifter */
`timescale 1ns/1ps

module sd_controller_top (
    input  logic        clk,
    input  logic        reset,
    output logic        cs,
    output logic        mosi,
    input  logic        miso,
    output logic        sclk,
    input  logic        rd,
    input  logic        wr,
    input  logic [31:0] address,
    input  logic [7:0]  din,
    output logic [7:0]  dout,
    output logic        byte_available,
    output logic        ready_for_next_byte,
    output logic        ready,
    output logic        error
);
    spi_byte_if sbus ();

    sd_cmd_sequencer seq0 (
        .clk                 (clk),
        .reset               (reset),
        .bus                 (sbus.seq),
        .cs                  (cs),
        .rd                  (rd),
        .wr                  (wr),
        .address             (address),
        .din                 (din),
        .dout                (dout),
        .byte_available      (byte_available),
        .ready_for_next_byte (ready_for_next_byte),
        .ready               (ready),
        .error               (error)
    );

    sd_spi_shifter phy0 (
        .clk   (clk),
        .reset (reset),
        .bus   (sbus.phy),
        .mosi  (mosi),
        .miso  (miso),
        .sclk  (sclk)
    );

endmodule

// ==== sd_card_model.sv ====
/* SPI-mode SDHC card model for the testbench: four-block store, scripted
   ACMD41 idle replies, rejected writes to one block and busy after writes */
`timescale 1ns/1ps

module sd_card_model #(
    parameter int ACMD41_BUSY  = 3,
    parameter int BUSY_REPEAT  = 4,
    parameter int REJECT_BLOCK = 3
) (
    input  logic cs,
    input  logic sclk,
    input  logic mosi,
    output logic miso
);
    logic [7:0] mem [0:2047];
    logic [7:0] wbuf [0:511];
    logic [7:0] cbuf [0:5];
    logic [7:0] q [$];
    logic [7:0] in_sh;
    logic [7:0] out_sh;
    logic [7:0] nxt;
    logic       load_pending;
    logic [1:0] wblk;
    int         bitn;
    int         mode;
    int         cnt;
    int         idle_left;

    assign miso = cs ? 1'b1 : out_sh[7];

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 8'((i / 512) * 16 + (i % 512));
        end
        out_sh       = 8'hFF;
        in_sh        = 8'hFF;
        nxt          = 8'hFF;
        load_pending = 1'b0;
        bitn         = 0;
        mode         = 0;
        cnt          = 0;
        idle_left    = ACMD41_BUSY;
        wblk         = 2'd0;
    end

    // queue the reply to a complete six-byte command
    task automatic run_cmd();
        logic [5:0]  idx;
        logic [31:0] arg;
        int          base;
        idx  = cbuf[0][5:0];
        arg  = {cbuf[1], cbuf[2], cbuf[3], cbuf[4]};
        base = int'(arg[1:0]) * 512;
        q.push_back(8'hFF);
        case (idx)
            6'd0: q.push_back(8'h01);
            6'd8: begin
                q.push_back(8'h01);
                q.push_back(8'h00);
                q.push_back(8'h00);
                q.push_back(8'h01);
                q.push_back(8'hAA);
            end
            6'd55: q.push_back(idle_left > 0 ? 8'h01 : 8'h00);
            6'd41: begin
                if (idle_left > 0) begin
                    q.push_back(8'h01);
                    idle_left = idle_left - 1;
                end else begin
                    q.push_back(8'h00);
                end
            end
            6'd58: begin
                q.push_back(8'h00);
                q.push_back(8'hC0);
                q.push_back(8'hFF);
                q.push_back(8'h80);
                q.push_back(8'h00);
            end
            6'd16: q.push_back(8'h00);
            6'd17: begin
                q.push_back(8'h00);
                q.push_back(8'hFF);
                q.push_back(8'hFE);
                for (int i = 0; i < 512; i++) begin
                    q.push_back(mem[base + i]);
                end
                q.push_back(8'hFF);
                q.push_back(8'hFF);
            end
            6'd24: begin
                q.push_back(8'h00);
                wblk = arg[1:0];
                mode = 2;
            end
            default: q.push_back(8'h04);  // illegal command
        endcase
    endtask

    // modes: 0 idle, 1 command bytes, 2 token wait, 3 write data, 4 write crc
    task automatic handle_byte(input logic [7:0] b);
        case (mode)
            0: begin
                if (b[7:6] == 2'b01) begin
                    cbuf[0] = b;
                    cnt     = 1;
                    mode    = 1;
                end
            end
            1: begin
                cbuf[cnt] = b;
                cnt       = cnt + 1;
                if (cnt == 6) begin
                    mode = 0;
                    run_cmd();
                end
            end
            2: begin
                if (b == 8'hFE) begin
                    cnt  = 0;
                    mode = 3;
                end
            end
            3: begin
                wbuf[cnt] = b;
                cnt       = cnt + 1;
                if (cnt == 512) begin
                    cnt  = 0;
                    mode = 4;
                end
            end
            default: begin
                cnt = cnt + 1;
                if (cnt == 2) begin
                    mode = 0;
                    if (int'(wblk) == REJECT_BLOCK) begin
                        q.push_back(8'h0B);
                    end else begin
                        for (int i = 0; i < 512; i++) begin
                            mem[int'(wblk) * 512 + i] = wbuf[i];
                        end
                        q.push_back(8'h05);
                        for (int i = 0; i < BUSY_REPEAT; i++) begin
                            q.push_back(8'h00);
                        end
                    end
                end
            end
        endcase
    endtask

    // mode 0 card: sample on rising sclk, next bit on falling sclk
    always @(posedge sclk) begin
        if (!cs) begin
            in_sh = {in_sh[6:0], mosi};
            bitn  = bitn + 1;
            if (bitn == 8) begin
                bitn = 0;
                handle_byte(in_sh);
                nxt          = (q.size() > 0) ? q.pop_front() : 8'hFF;
                load_pending = 1'b1;
            end
        end
    end

    always @(negedge sclk) begin
        if (!cs) begin
            if (load_pending) begin
                out_sh       = nxt;
                load_pending = 1'b0;
            end else begin
                out_sh = {out_sh[6:0], 1'b1};
            end
        end
    end

endmodule

// ==== sd_assertions.sv ====
/* handshake rules of the SD controller top, bound onto every instance */
`timescale 1ns/1ps

module sd_assertions (
    input logic clk,
    input logic reset,
    input logic cs,
    input logic sclk,
    input logic ready,
    input logic byte_available,
    input logic ready_for_next_byte,
    input logic error
);
    logic powered;

    always_ff @(posedge clk) begin
        if (reset) begin
            powered <= 1'b0;
        end else if (ready) begin
            powered <= 1'b1;
        end
    end

    a_strobes_apart: assert property (@(posedge clk) disable iff (reset)
        !(byte_available && ready_for_next_byte))
        else $error("byte_available and ready_for_next_byte high together");

    a_quiet_when_ready: assert property (@(posedge clk) disable iff (reset)
        ready |-> !(byte_available || ready_for_next_byte))
        else $error("data strobe while ready");

    a_sclk_idle: assert property (@(posedge clk) disable iff (reset)
        (powered && cs) |-> !sclk)
        else $error("sclk toggles with cs high");

    a_error_pulse: assert property (@(posedge clk) disable iff (reset)
        error |=> !error)
        else $error("error held for two cycles");

endmodule

bind sd_controller_top sd_assertions asrt0 (
    .clk                 (clk),
    .reset               (reset),
    .cs                  (cs),
    .sclk                (sclk),
    .ready               (ready),
    .byte_available      (byte_available),
    .ready_for_next_byte (ready_for_next_byte),
    .error               (error)
);

// ==== tb_sd_controller.sv ====
/* SD controller testbench running power-up and then a table of block reads
   and writes against the card model, checked against a shadow store */
`timescale 1ns/1ps

module tb_sd_controller;
    localparam int ACMD41_BUSY   = 3;
    localparam int BUSY_REPEAT   = 6;
    localparam int REJECT_BLOCK  = 3;
    localparam int READY_TIMEOUT = 200000;
    localparam int XFER_TIMEOUT  = 100000;
    localparam int N_ENTRIES     = 7;

    // op 0 read, 1 write, 2 read and write raised together
    typedef struct packed {
        logic [1:0] op;
        logic [1:0] blk;
        logic       exp_err;
    } entry_t;

    logic        clk;
    logic        reset;
    logic        cs;
    logic        mosi;
    logic        miso;
    logic        sclk;
    logic        rd;
    logic        wr;
    logic [31:0] address;
    logic [7:0]  din;
    logic [7:0]  dout;
    logic        byte_available;
    logic        ready_for_next_byte;
    logic        ready;
    logic        error;

    entry_t      table_e [0:N_ENTRIES-1];
    logic [7:0]  shadow [0:2047];
    integer      seed;
    int          errors;

    sd_controller_top dut0 (.*);

    sd_card_model #(
        .ACMD41_BUSY  (ACMD41_BUSY),
        .BUSY_REPEAT  (BUSY_REPEAT),
        .REJECT_BLOCK (REJECT_BLOCK)
    ) card0 (
        .cs   (cs),
        .sclk (sclk),
        .mosi (mosi),
        .miso (miso)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_ready(input int limit, output bit ok, output int err_seen);
        int n;
        n        = 0;
        err_seen = 0;
        while (!ready && n < limit) begin
            if (error) err_seen++;
            @(negedge clk);
            n++;
        end
        ok = ready;
        if (!ok) begin
            $display("timeout: ready did not rise within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic run_entry(input entry_t e, output bit ok);
        int         base;
        int         rcount;
        int         wcount;
        int         ecount;
        int         n;
        logic [7:0] wdata [0:511];
        base   = int'(e.blk) * 512;
        rcount = 0;
        wcount = 0;
        ecount = 0;
        n      = 0;
        for (int i = 0; i < 512; i++) begin
            wdata[i] = 8'($random(seed));
        end
        @(negedge clk);
        rd      = (e.op != 2'd1);
        wr      = (e.op != 2'd0);
        address = {30'd0, e.blk};
        @(negedge clk);
        rd = 1'b0;
        wr = 1'b0;
        while (!ready && n < XFER_TIMEOUT) begin
            if (byte_available) begin
                if (rcount < 512) begin
                    check_value("dout", {24'd0, dout},
                                {24'd0, shadow[base + rcount]});
                end
                rcount++;
            end
            if (ready_for_next_byte) begin
                if (wcount < 512) din = wdata[wcount];
                wcount++;
            end
            if (error) ecount++;
            @(negedge clk);
            n++;
        end
        // a failed write returns to ready on the same edge as its error pulse
        if (error) ecount++;
        ok = ready;
        if (!ok) begin
            $display("timeout: transfer on block %0d did not finish", e.blk);
            errors++;
        end
        check_value("byte_available count", rcount, (e.op != 2'd1) ? 512 : 0);
        check_value("ready_for_next_byte count", wcount, (e.op == 2'd1) ? 512 : 0);
        check_value("error count", ecount, {31'd0, e.exp_err});
        if (e.op == 2'd1 && !e.exp_err) begin
            for (int i = 0; i < 512; i++) begin
                shadow[base + i] = wdata[i];
            end
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin
        bit ok;
        int err_seen;
        clk     = 1'b0;
        reset   = 1'b1;
        rd      = 1'b0;
        wr      = 1'b0;
        address = 32'd0;
        din     = 8'd0;
        errors  = 0;
        seed    = 32'h152f7742;
        table_e[0] = '{op: 2'd0, blk: 2'd1, exp_err: 1'b0};
        table_e[1] = '{op: 2'd1, blk: 2'd2, exp_err: 1'b0};
        table_e[2] = '{op: 2'd0, blk: 2'd2, exp_err: 1'b0};
        table_e[3] = '{op: 2'd0, blk: 2'd0, exp_err: 1'b0};
        table_e[4] = '{op: 2'd1, blk: 2'd3, exp_err: 1'b1};
        table_e[5] = '{op: 2'd0, blk: 2'd3, exp_err: 1'b0};
        table_e[6] = '{op: 2'd2, blk: 2'd1, exp_err: 1'b0};
        for (int i = 0; i < 2048; i++) begin
            shadow[i] = 8'((i / 512) * 16 + (i % 512));
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;
        check_value("cs", {31'd0, cs}, 32'd1);
        check_value("sclk", {31'd0, sclk}, 32'd0);
        check_value("mosi", {31'd0, mosi}, 32'd1);
        check_value("ready", {31'd0, ready}, 32'd0);
        check_value("byte_available", {31'd0, byte_available}, 32'd0);
        check_value("ready_for_next_byte", {31'd0, ready_for_next_byte}, 32'd0);
        check_value("error", {31'd0, error}, 32'd0);
        wait_ready(READY_TIMEOUT, ok, err_seen);
        check_value("power-up error count", err_seen, 32'd0);
        for (int i = 0; i < N_ENTRIES && ok; i++) begin
            run_entry(table_e[i], ok);
        end
        finish_run();
    end

endmodule

// ==== list.f ====
+incdir+.
sd_pkg.sv
spi_byte_if.sv
sd_spi_shifter.sv
sd_cmd_sequencer.sv
sd_controller_top.sv
sd_card_model.sv
sd_assertions.sv
tb_sd_controller.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sd_controller
DUT_TOP   ?= sd_controller_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
